// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    // ==============================
    // widths
    // ==============================
    typedef logic [31:0] word_t;     // data, address, instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // ==============================
    // major opcodes
    // ==============================
    localparam opcode_t op_rtype  = 7'b0110011;
    localparam opcode_t op_itype  = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b      // lui
    } alu_op_e;

    // ==============================
    // stage control vectors
    // ==============================
    typedef logic [6:0] ex_ctrl_t;
    typedef logic [3:0] mm_ctrl_t;

    localparam int ec_use_imm   = 0;
    localparam int ec_reg_write = 1;
    localparam int ec_mem_read  = 2;
    localparam int ec_mem_write = 3;
    localparam int ec_branch    = 4;
    localparam int ec_branch_ne = 5;
    localparam int ec_jump      = 6;

    localparam int mc_reg_write = 0;
    localparam int mc_mem_read  = 1;
    localparam int mc_mem_write = 2;
    localparam int mc_link      = 3;    // write back pc+4

    // memory-mapped I/O
    localparam word_t led_addr = 32'h0000_0ff0;
    localparam word_t sw_addr  = 32'h0000_0ff4;

endpackage

// ==== rtl/cpu_intf.sv ====
`timescale 1ns/1ps

// MEM/WB result, seen by the register file and the forwarding muxes
interface wb_bus_if;
    logic             we;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::word_t   data;
    logic             valid;

    modport src (
        output we,
        output rd,
        output data,
        output valid
    );

    modport snk (
        input  we,
        input  rd,
        input  data,
        input  valid
    );
endinterface

interface dmem_if;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t wdata;
    logic           we;
    logic           re;
    cpu_pkg::word_t rdata;    // OR of all slaves, built at top

    modport master (
        output addr,
        output wdata,
        output we,
        output re,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        input  re
    );
endinterface

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_WORDS = 256
) (
    input  logic           cpuclk,
    input  logic           rst_n,
    input  logic           prog_we,
    input  cpu_pkg::word_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t target,
    output cpu_pkg::word_t id_pc,
    output cpu_pkg::word_t id_inst,
    output logic           id_valid
);

    localparam int IA_W = $clog2(IMEM_WORDS);

    cpu_pkg::word_t imem [IMEM_WORDS];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t if_inst;

    always_ff @(posedge cpuclk) begin
        if (!rst_n && prog_we) begin
            imem[prog_addr[IA_W+1:2]] <= prog_data;    // byte address in
        end
    end

    assign if_inst = imem[pc[IA_W+1:2]];

    always_ff @(posedge cpuclk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (redirect) begin
            pc       <= target;
            id_valid <= 1'b0;    // drop the fetch behind the branch
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge cpuclk) begin
        if (!stall) begin
            id_pc   <= pc;
            id_inst <= if_inst;
        end
    end

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic              cpuclk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    id_pc,
    input  cpu_pkg::word_t    id_inst,
    input  logic              id_valid,
    input  logic              redirect,
    wb_bus_if.snk             wb,
    output logic              stall,
    output cpu_pkg::word_t    ex_pc,
    output cpu_pkg::word_t    ex_rs1_val,
    output cpu_pkg::word_t    ex_rs2_val,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::reg_idx_t ex_rs1,
    output cpu_pkg::reg_idx_t ex_rs2,
    output cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::alu_op_e  ex_alu_op,
    output cpu_pkg::ex_ctrl_t ex_ctrl,
    output logic              ex_valid
);

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t rs1, rs2, rd;
    logic [2:0]        funct3;
    cpu_pkg::word_t    regs [32];
    cpu_pkg::word_t    rs1_val, rs2_val, imm;
    cpu_pkg::ex_ctrl_t ctrl;
    cpu_pkg::alu_op_e  alu_op, funct_op;
    logic              uses_rs1, uses_rs2;

    assign opcode = id_inst[6:0];
    assign rd     = id_inst[11:7];
    assign funct3 = id_inst[14:12];
    assign rs1    = id_inst[19:15];
    assign rs2    = id_inst[24:20];

    always_comb begin
        case (funct3)
            3'b111:  funct_op = cpu_pkg::alu_and;
            3'b110:  funct_op = cpu_pkg::alu_or;
            3'b100:  funct_op = cpu_pkg::alu_xor;
            3'b010:  funct_op = cpu_pkg::alu_slt;
            default: funct_op = cpu_pkg::alu_add;
        endcase
    end

    // ==============================
    // control and immediate
    // ==============================
    always_comb begin
        ctrl     = '0;
        alu_op   = cpu_pkg::alu_add;
        imm      = {{20{id_inst[31]}}, id_inst[31:20]};    // I type
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            cpu_pkg::op_rtype: begin
                ctrl[cpu_pkg::ec_reg_write] = 1'b1;
                uses_rs2 = 1'b1;
                alu_op   = (funct3 == 3'b000 && id_inst[30]) ? cpu_pkg::alu_sub : funct_op;
            end
            cpu_pkg::op_itype: begin
                ctrl[cpu_pkg::ec_reg_write] = 1'b1;
                ctrl[cpu_pkg::ec_use_imm]   = 1'b1;
                alu_op = funct_op;
            end
            cpu_pkg::op_lui: begin
                ctrl[cpu_pkg::ec_reg_write] = 1'b1;
                ctrl[cpu_pkg::ec_use_imm]   = 1'b1;
                alu_op   = cpu_pkg::alu_pass_b;
                imm      = {id_inst[31:12], 12'b0};
                uses_rs1 = 1'b0;
            end
            cpu_pkg::op_load: begin
                ctrl[cpu_pkg::ec_reg_write] = 1'b1;
                ctrl[cpu_pkg::ec_use_imm]   = 1'b1;
                ctrl[cpu_pkg::ec_mem_read]  = 1'b1;
            end
            cpu_pkg::op_store: begin
                ctrl[cpu_pkg::ec_use_imm]   = 1'b1;
                ctrl[cpu_pkg::ec_mem_write] = 1'b1;
                imm      = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
                uses_rs2 = 1'b1;
            end
            cpu_pkg::op_branch: begin
                ctrl[cpu_pkg::ec_branch]    = 1'b1;
                ctrl[cpu_pkg::ec_branch_ne] = funct3[0];    // bne
                imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7],
                       id_inst[30:25], id_inst[11:8], 1'b0};
                uses_rs2 = 1'b1;
            end
            cpu_pkg::op_jal: begin
                ctrl[cpu_pkg::ec_reg_write] = 1'b1;
                ctrl[cpu_pkg::ec_jump]      = 1'b1;
                imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12],
                       id_inst[20], id_inst[30:21], 1'b0};
                uses_rs1 = 1'b0;
            end
            default: uses_rs1 = 1'b0;    // unsupported, becomes a nop
        endcase
    end

    // register file, write-through on a same-cycle read
    always_ff @(posedge cpuclk) begin
        if (wb.valid && wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 :
                     (wb.valid && wb.we && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 :
                     (wb.valid && wb.we && wb.rd == rs2) ? wb.data : regs[rs2];

    // load in ID/EX feeding this instruction
    assign stall = id_valid && ex_valid && ex_ctrl[cpu_pkg::ec_mem_read] && ex_rd != '0 &&
                   ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

    always_ff @(posedge cpuclk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else if (redirect || stall || !id_valid) begin
            ex_valid <= 1'b0;    // bubble
            ex_ctrl  <= '0;
        end else begin
            ex_valid <= 1'b1;
            ex_ctrl  <= ctrl;
        end
    end

    always_ff @(posedge cpuclk) begin
        ex_pc      <= id_pc;
        ex_rs1_val <= rs1_val;
        ex_rs2_val <= rs2_val;
        ex_imm     <= imm;
        ex_rs1     <= rs1;
        ex_rs2     <= rs2;
        ex_rd      <= rd;
        ex_alu_op  <= alu_op;
    end

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic              cpuclk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::word_t    ex_rs1_val,
    input  cpu_pkg::word_t    ex_rs2_val,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::reg_idx_t ex_rs1,
    input  cpu_pkg::reg_idx_t ex_rs2,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::alu_op_e  ex_alu_op,
    input  cpu_pkg::ex_ctrl_t ex_ctrl,
    input  logic              ex_valid,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  cpu_pkg::word_t    mem_result,
    input  logic              mem_we,
    wb_bus_if.snk             wb,
    output logic              redirect,
    output cpu_pkg::word_t    target,
    output cpu_pkg::word_t    mm_alu,
    output cpu_pkg::word_t    mm_store,
    output cpu_pkg::reg_idx_t mm_rd,
    output cpu_pkg::mm_ctrl_t mm_ctrl,
    output cpu_pkg::word_t    mm_pc4,
    output logic              mm_valid
);

    logic              fwd_mem_a, fwd_wb_a, fwd_mem_b, fwd_wb_b;
    cpu_pkg::word_t    op_a, op_b, alu_b, alu_out;
    logic              taken;
    cpu_pkg::mm_ctrl_t mm_ctrl_d;

    // ==============================
    // forwarding, nearest first
    // ==============================
    assign fwd_mem_a = mem_we && mem_rd != '0 && mem_rd == ex_rs1;
    assign fwd_wb_a  = wb.valid && wb.we && wb.rd != '0 && wb.rd == ex_rs1;
    assign fwd_mem_b = mem_we && mem_rd != '0 && mem_rd == ex_rs2;
    assign fwd_wb_b  = wb.valid && wb.we && wb.rd != '0 && wb.rd == ex_rs2;

    assign op_a = fwd_mem_a ? mem_result : fwd_wb_a ? wb.data : ex_rs1_val;
    assign op_b = fwd_mem_b ? mem_result : fwd_wb_b ? wb.data : ex_rs2_val;

    assign alu_b = ex_ctrl[cpu_pkg::ec_use_imm] ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::alu_sub: alu_out = op_a - alu_b;
            cpu_pkg::alu_and: alu_out = op_a & alu_b;
            cpu_pkg::alu_or:  alu_out = op_a | alu_b;
            cpu_pkg::alu_xor: alu_out = op_a ^ alu_b;
            cpu_pkg::alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::alu_pass_b: alu_out = alu_b;
            default:          alu_out = op_a + alu_b;
        endcase
    end

    // beq/bne compare registers, not the immediate
    assign taken = ex_ctrl[cpu_pkg::ec_jump] ||
                   (ex_ctrl[cpu_pkg::ec_branch] &&
                    ((op_a == op_b) ^ ex_ctrl[cpu_pkg::ec_branch_ne]));

    assign redirect = ex_valid && taken;
    assign target   = ex_pc + ex_imm;

    always_comb begin
        mm_ctrl_d = '0;
        mm_ctrl_d[cpu_pkg::mc_reg_write] = ex_ctrl[cpu_pkg::ec_reg_write];
        mm_ctrl_d[cpu_pkg::mc_mem_read]  = ex_ctrl[cpu_pkg::ec_mem_read];
        mm_ctrl_d[cpu_pkg::mc_mem_write] = ex_ctrl[cpu_pkg::ec_mem_write];
        mm_ctrl_d[cpu_pkg::mc_link]      = ex_ctrl[cpu_pkg::ec_jump];
    end

    always_ff @(posedge cpuclk or negedge rst_n) begin
        if (!rst_n) begin
            mm_valid <= 1'b0;
            mm_ctrl  <= '0;
        end else begin
            mm_valid <= ex_valid;
            mm_ctrl  <= ex_valid ? mm_ctrl_d : '0;
        end
    end

    always_ff @(posedge cpuclk) begin
        mm_alu   <= alu_out;
        mm_store <= op_b;
        mm_rd    <= ex_rd;
        mm_pc4   <= ex_pc + 32'd4;
    end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic              cpuclk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    mm_alu,
    input  cpu_pkg::word_t    mm_store,
    input  cpu_pkg::reg_idx_t mm_rd,
    input  cpu_pkg::mm_ctrl_t mm_ctrl,
    input  cpu_pkg::word_t    mm_pc4,
    input  logic              mm_valid,
    dmem_if.master            dmem,
    output cpu_pkg::word_t    mem_result,
    wb_bus_if.src             wb,
    output logic              retire_valid,
    output cpu_pkg::word_t    retire_pc,
    output cpu_pkg::reg_idx_t retire_rd,
    output logic              retire_we,
    output cpu_pkg::word_t    retire_data
);

    assign dmem.addr  = mm_alu;
    assign dmem.wdata = mm_store;
    assign dmem.we    = mm_ctrl[cpu_pkg::mc_mem_write];
    assign dmem.re    = mm_ctrl[cpu_pkg::mc_mem_read];

    // also the EX/MEM forwarding value
    assign mem_result = mm_ctrl[cpu_pkg::mc_mem_read] ? dmem.rdata :
                        mm_ctrl[cpu_pkg::mc_link]     ? mm_pc4     : mm_alu;

    // ==============================
    // MEM/WB
    // ==============================
    always_ff @(posedge cpuclk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= mm_valid;
            retire_we    <= mm_valid && mm_ctrl[cpu_pkg::mc_reg_write];
        end
    end

    always_ff @(posedge cpuclk) begin
        retire_pc   <= mm_pc4 - 32'd4;
        retire_rd   <= mm_rd;
        retire_data <= mem_result;
    end

    assign wb.valid = retire_valid;
    assign wb.we    = retire_we;
    assign wb.rd    = retire_rd;
    assign wb.data  = retire_data;

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic           cpuclk,
    dmem_if.slave          dmem,
    output cpu_pkg::word_t rdata_ram
);

    localparam int AW = $clog2(DMEM_WORDS);

    cpu_pkg::word_t ram [DMEM_WORDS];
    logic           hit;
    logic [AW-1:0]  widx;

    assign hit  = dmem.addr < cpu_pkg::word_t'(4 * DMEM_WORDS);
    assign widx = dmem.addr[AW+1:2];    // word addressed

    always_ff @(posedge cpuclk) begin
        if (dmem.we && hit) begin
            ram[widx] <= dmem.wdata;
        end
    end

    // zero when another slave owns the address
    assign rdata_ram = (dmem.re && hit) ? ram[widx] : '0;

endmodule

// ==== rtl/mmio_regs.sv ====
`timescale 1ns/1ps

module mmio_regs (
    input  logic           cpuclk,
    input  logic           rst_n,
    dmem_if.slave          dmem,
    input  logic [7:0]     switches,
    output cpu_pkg::word_t led_out,
    output cpu_pkg::word_t rdata_io
);

    logic [7:0] sw_meta, sw_sync;

    always_ff @(posedge cpuclk or negedge rst_n) begin
        if (!rst_n) begin
            led_out <= '0;
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= switches;    // async input
            sw_sync <= sw_meta;
            if (dmem.we && dmem.addr == cpu_pkg::led_addr) begin
                led_out <= dmem.wdata;
            end
        end
    end

    assign rdata_io = (dmem.re && dmem.addr == cpu_pkg::sw_addr) ? {24'b0, sw_sync} : '0;

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic              cpuclk,
    input  logic              rst_n,
    input  logic [7:0]        switches,
    input  logic              prog_we,
    input  cpu_pkg::word_t    prog_addr,
    input  cpu_pkg::word_t    prog_data,
    output cpu_pkg::word_t    led_out,
    output logic              retire_valid,
    output cpu_pkg::word_t    retire_pc,
    output cpu_pkg::reg_idx_t retire_rd,
    output logic              retire_we,
    output cpu_pkg::word_t    retire_data
);

    wb_bus_if u_wb_bus ();
    dmem_if   u_dmem ();

    logic              stall, redirect, id_valid, ex_valid, mm_valid, mem_we;
    cpu_pkg::word_t    target, id_pc, id_inst;
    cpu_pkg::word_t    ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
    cpu_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd, mm_rd;
    cpu_pkg::alu_op_e  ex_alu_op;
    cpu_pkg::ex_ctrl_t ex_ctrl;
    cpu_pkg::mm_ctrl_t mm_ctrl;
    cpu_pkg::word_t    mm_alu, mm_store, mm_pc4, mem_result;
    cpu_pkg::word_t    rdata_ram, rdata_io;

    assign mem_we         = mm_valid && mm_ctrl[cpu_pkg::mc_reg_write];
    assign u_dmem.rdata   = rdata_ram | rdata_io;

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .cpuclk, .rst_n, .prog_we, .prog_addr, .prog_data,
        .stall, .redirect, .target, .id_pc, .id_inst, .id_valid
    );

    decode_unit u_decode (
        .cpuclk, .rst_n, .id_pc, .id_inst, .id_valid, .redirect,
        .wb(u_wb_bus.snk), .stall,
        .ex_pc, .ex_rs1_val, .ex_rs2_val, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
        .ex_alu_op, .ex_ctrl, .ex_valid
    );

    execute_unit u_execute (
        .cpuclk, .rst_n,
        .ex_pc, .ex_rs1_val, .ex_rs2_val, .ex_imm, .ex_rs1, .ex_rs2, .ex_rd,
        .ex_alu_op, .ex_ctrl, .ex_valid,
        .mem_rd(mm_rd), .mem_result, .mem_we, .wb(u_wb_bus.snk),
        .redirect, .target, .mm_alu, .mm_store, .mm_rd, .mm_ctrl, .mm_pc4, .mm_valid
    );

    mem_stage u_mem (
        .cpuclk, .rst_n, .mm_alu, .mm_store, .mm_rd, .mm_ctrl, .mm_pc4, .mm_valid,
        .dmem(u_dmem.master), .mem_result, .wb(u_wb_bus.src),
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
    );

    data_memory #(.DMEM_WORDS(DMEM_WORDS)) u_dmem_ram (
        .cpuclk, .dmem(u_dmem.slave), .rdata_ram
    );

    mmio_regs u_mmio (
        .cpuclk, .rst_n, .dmem(u_dmem.slave), .switches, .led_out, .rdata_io
    );

endmodule

// ==== tb/tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

typedef struct packed {
    cpu_pkg::word_t    pc;
    cpu_pkg::reg_idx_t rd;
    logic              we;
    cpu_pkg::word_t    data;
    cpu_pkg::word_t    led;     // led_out once this instruction retires
} retire_rec_t;

localparam cpu_pkg::word_t halt_inst = 32'h0000_006f;    // jal x0, 0
localparam cpu_pkg::word_t nop_inst  = 32'h0000_0013;

cpu_pkg::word_t lcg_state = 32'h4a9de10e;
cpu_pkg::word_t prog_mem [256];
int             prog_len;
cpu_pkg::word_t arch_regs [32];
cpu_pkg::word_t arch_dmem [256];
cpu_pkg::word_t arch_led;
retire_rec_t    exp_q [$];
logic [2:0]     alu_f3 [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};    // addi/andi/ori first

function automatic int pick(int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'({8'b0, lcg_state[31:8]}) % n;
endfunction

// ==============================
// instruction encoders
// ==============================
function automatic cpu_pkg::word_t enc_r(logic [2:0] f3, logic sub, int rd, int rs1, int rs2);
    return {1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), cpu_pkg::op_rtype};
endfunction

function automatic cpu_pkg::word_t enc_i(cpu_pkg::opcode_t op, logic [2:0] f3, int rd,
                                         int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic cpu_pkg::word_t enc_s(int rs2, int rs1, int imm);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], cpu_pkg::op_store};
endfunction

function automatic cpu_pkg::word_t enc_b(logic ne, int rs1, int rs2, int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, o[4:1], o[11], cpu_pkg::op_branch};
endfunction

function automatic cpu_pkg::word_t enc_j(int rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), cpu_pkg::op_jal};
endfunction

function automatic cpu_pkg::word_t enc_u(int rd, int imm);
    return {20'(imm), 5'(rd), cpu_pkg::op_lui};
endfunction

function automatic void emit(cpu_pkg::word_t w);
    prog_mem[prog_len] = w;
    prog_len++;
endfunction

// ==============================
// program generator
// ==============================
function automatic void gen_program(int n_body);
    int         rd, rs1, rs2, k;
    logic [2:0] f3;
    prog_len = 0;
    for (int r = 1; r < 30; r++) begin
        emit(enc_i(cpu_pkg::op_itype, 3'b000, r, 0, pick(4096) - 2048));
    end
    emit(enc_u(30, 1));
    emit(enc_i(cpu_pkg::op_itype, 3'b000, 30, 30, -16));    // x30 = led_addr
    emit(enc_i(cpu_pkg::op_itype, 3'b000, 31, 0, 256));     // x31 = data window
    for (int w = 0; w < 16; w++) begin
        emit(enc_s(1 + pick(29), 31, 4 * w));
    end
    for (int i = 0; i < n_body; i++) begin
        rd  = pick(8);    // small pool for many hazards
        rs1 = pick(8);
        rs2 = pick(8);
        k   = 4 * pick(16);
        f3  = alu_f3[pick(5)];
        case (pick(8))
            0: emit(enc_r(f3, f3 == 3'b000 && pick(2) == 1, rd, rs1, rs2));
            1: emit(enc_i(cpu_pkg::op_itype, alu_f3[pick(3)], rd, rs1, pick(4096) - 2048));
            2: emit(enc_u(rd, pick(1 << 20)));
            3: begin    // load then use
                emit(enc_i(cpu_pkg::op_load, 3'b010, rd, 31, k));
                emit(enc_r(f3, 1'b0, rs2, rd, rs1));
            end
            4: begin
                emit(enc_s(rs2, 31, k));
                emit(enc_i(cpu_pkg::op_load, 3'b010, rd, 31, k));
            end
            5: begin    // skip one when taken
                emit(enc_b(pick(2) == 1, rs1, rs2, 8));
                emit(enc_i(cpu_pkg::op_itype, 3'b000, rd, rs1, 1));
            end
            6: begin
                emit(enc_j(rd, 8));
                emit(enc_i(cpu_pkg::op_itype, 3'b000, rs1, rs2, 7));
            end
            default: begin
                if (pick(2) == 1) begin
                    emit(enc_s(rs1, 30, 0));
                end else begin
                    emit(enc_i(cpu_pkg::op_load, 3'b010, rd, 30, 4));
                end
            end
        endcase
    end
    emit(halt_inst);
    emit(nop_inst);    // keeps the flushed fetches defined
    emit(nop_inst);
endfunction

// ==============================
// instruction-set reference
// ==============================
function automatic cpu_pkg::word_t alu_ref(logic [2:0] f3, logic sub, cpu_pkg::word_t a,
                                           cpu_pkg::word_t b);
    case (f3)
        3'b111:  return a & b;
        3'b110:  return a | b;
        3'b100:  return a ^ b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: return sub ? a - b : a + b;
    endcase
endfunction

function automatic void run_model(logic [7:0] sw);
    cpu_pkg::word_t pc, next_pc, inst, a, b, res, addr, imm_i, imm_s;
    logic           we;
    pc           = '0;
    arch_led     = '0;
    arch_regs[0] = '0;
    for (int n = 0; n < 1024; n++) begin
        inst    = prog_mem[pc[9:2]];
        a       = arch_regs[inst[19:15]];
        b       = arch_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        res     = '0;
        we      = 1'b1;
        next_pc = pc + 32'd4;
        case (inst[6:0])
            cpu_pkg::op_rtype: res = alu_ref(inst[14:12], inst[30], a, b);
            cpu_pkg::op_itype: res = alu_ref(inst[14:12], 1'b0, a, imm_i);
            cpu_pkg::op_lui:   res = {inst[31:12], 12'b0};
            cpu_pkg::op_load: begin
                addr = a + imm_i;
                res  = (addr == cpu_pkg::sw_addr) ? {24'b0, sw} : arch_dmem[addr[9:2]];
            end
            cpu_pkg::op_store: begin
                addr = a + imm_s;
                we   = 1'b0;
                if (addr == cpu_pkg::led_addr) begin
                    arch_led = b;
                end else begin
                    arch_dmem[addr[9:2]] = b;
                end
            end
            cpu_pkg::op_branch: begin
                we = 1'b0;
                if ((a == b) != inst[12]) begin
                    next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
                end
            end
            default: begin    // jal
                res     = pc + 32'd4;
                next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            end
        endcase
        if (we && inst[11:7] != 5'd0) begin
            arch_regs[inst[11:7]] = res;
        end
        exp_q.push_back(retire_rec_t'{pc, inst[11:7], we, res, arch_led});
        if (inst == halt_inst) begin
            break;
        end
        pc = next_pc;
    end
endfunction

`endif

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

    localparam int n_programs = 6;
    localparam int body_len   = 40;

    logic              cpuclk = 1'b0;
    logic              rst_n;
    logic [7:0]        switches;
    logic              prog_we;
    cpu_pkg::word_t    prog_addr;
    cpu_pkg::word_t    prog_data;
    cpu_pkg::word_t    led_out;
    logic              retire_valid;
    cpu_pkg::word_t    retire_pc;
    cpu_pkg::reg_idx_t retire_rd;
    logic              retire_we;
    cpu_pkg::word_t    retire_data;

    int                pending;      // model records not yet retired
    cpu_pkg::word_t    halt_pc;
    int                cycles;
    int                cycle_limit;

    `include "tb_cpu_model.svh"

    cpu_top #(.IMEM_WORDS(256), .DMEM_WORDS(256)) u_cpu_top (
        .cpuclk, .rst_n, .switches, .prog_we, .prog_addr, .prog_data, .led_out,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
    );

    always #4 cpuclk = ~cpuclk;

    // ==============================
    // compare tasks
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input cpu_pkg::reg_idx_t got,
                             input cpu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // ==============================
    // retire monitor and timeout
    // ==============================
    always @(posedge cpuclk) begin
        retire_rec_t e;
        if (rst_n && retire_valid) begin
            if (pending == 0) begin
                if (retire_pc !== halt_pc) begin    // only the halt loop may repeat
                    abort_run("an instruction retired after the program had ended");
                end
            end else begin
                e = exp_q.pop_front();
                pending--;
                check_word("retire_pc", retire_pc, e.pc);
                check_bit("retire_we", retire_we, e.we);
                if (e.we) begin
                    check_reg("retire_rd", retire_rd, e.rd);
                    check_word("retire_data", retire_data, e.data);
                end
                check_word("led_out", led_out, e.led);
            end
        end
    end

    always @(posedge cpuclk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                abort_run("timeout, the program did not finish within its cycle limit");
            end
        end
    end

    task automatic run_program();
        @(negedge cpuclk);
        rst_n    = 1'b0;
        switches = 8'(pick(256));    // stable long before any load
        gen_program(body_len);
        run_model(switches);
        pending  = exp_q.size();
        halt_pc  = exp_q[$].pc;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge cpuclk);
            prog_we   = 1'b1;
            prog_addr = 32'(4 * i);
            prog_data = prog_mem[i];
        end
        @(negedge cpuclk);
        prog_we = 1'b0;
        repeat (2) @(negedge cpuclk);
        cycles      = 0;
        cycle_limit = 3 * pending + 20;
        rst_n       = 1'b1;
        while (pending != 0) begin
            @(negedge cpuclk);
        end
        repeat (4) @(negedge cpuclk);    // flushed fetches would show here
    endtask

    initial begin
        rst_n       = 1'b0;
        switches    = '0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        pending     = 0;
        halt_pc     = '0;
        cycles      = 0;
        cycle_limit = 0;
        for (int p = 0; p < n_programs; p++) begin
            run_program();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tb
rtl/cpu_pkg.sv
rtl/cpu_intf.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/mem_stage.sv
rtl/data_memory.sv
rtl/mmio_regs.sv
rtl/cpu_top.sv
tb/tb_cpu.sv
